/* compile.f */
+incdir+tests
verilog/spill_pkg.sv
verilog/sync_fifo.sv
verilog/id_free_list.sv
verilog/spill_coalescer.sv
verilog/spill_regs.sv
verilog/spill_subsystem.sv
tests/tb_spill_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the spill subsystem testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
      --top-module tb_spill_subsystem -f compile.f \
      -Mdir obj_dir -o sim > build.log 2>&1; then
   cat build.log
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "SIMULATION PASSED" sim.log; then
   exit 0
fi
exit 1

/* tests/tb_mem_model.svh */
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

   localparam int MEM_WORDS = 4096;

   logic [63:0] mem_words [MEM_WORDS];
   logic [15:0] stack_list [8] = '{16'd3, 16'd7, 16'd1, 16'd5, 16'd2, 16'd6, 16'd4, 16'd0};
   logic [63:0] rd_data_q [$];
   int          rd_due_q [$];
   logic [3:0]  ack_id_q [$];
   int          ack_due_q [$];
   int          ack_pick = -1;     // index of the acknowledge on the bus, -1 when idle
   int          ready_phase = 400; // child port starts with a long stall
   bit          ready_high = 0;

   task automatic mem_init();
      for (int a = 0; a < MEM_WORDS; a++) begin
         mem_words[12'(a)] = {~32'(a), 32'(a)};
      end
      mem_words[PTR_ADDR[11:0]] = 64'd0;   // stack pointer starts at the bottom
      for (int i = 0; i < 8; i++) begin
         mem_words[STACK_BASE[11:0] + 12'(i)] = 64'(stack_list[3'(i)]);
      end
   endtask

   task automatic mem_drive();
      int r;
      r = $random(seed);
      mem_req_ready = (r[1:0] != 2'b00);
      mem_rvalid    = 1'b0;
      if (rd_due_q.size() > 0 && rd_due_q[0] <= cyc) begin
         mem_rvalid = 1'b1;
         mem_rdata  = rd_data_q.pop_front();
         rd_due_q.delete(0);
      end
      // pick any due acknowledge and hold it until it is taken
      if (ack_pick < 0 && ack_id_q.size() > 0) begin
         ack_pick = int'(r[7:4]) % ack_id_q.size();
         if (ack_due_q[ack_pick] > cyc) ack_pick = -1;
      end
      mem_bvalid = (ack_pick >= 0);
      mem_bid    = (ack_pick >= 0) ? ack_id_q[ack_pick] : 4'd0;
      if (ready_phase == 0) begin
         ready_high  = !ready_high;
         ready_phase = 1 + int'(r[12:8]);
      end else begin
         ready_phase--;
      end
      child_ready = ready_high && r[14:13] != 2'b00;
   endtask

   task automatic mem_observe();
      int          r;
      logic [11:0] idx;
      r = $random(seed);
      if (mem_bvalid && mem_bready) begin
         ack_id_q.delete(ack_pick);
         ack_due_q.delete(ack_pick);
         ack_pick = -1;
      end
      if (mem_req_valid && mem_req_ready) begin
         if (mem_req.addr >= 32'(MEM_WORDS)) begin
            report_failure("memory request outside the modelled address range");
         end else begin
            idx = mem_req.addr[11:0];
            if (mem_req.we) begin
               mem_words[idx] = mem_req.wdata;
            end else begin
               rd_data_q.push_back(mem_words[idx]);
               rd_due_q.push_back(cyc + 1 + int'(r[1:0]) % 3);
            end
            if (mem_req.we && mem_req.last) begin
               ack_id_q.push_back(mem_req.id);
               ack_due_q.push_back(cyc + 1 + int'(r[5:3]));
            end
         end
      end
   endtask

`endif

/* tests/tb_spill_subsystem.sv */
`timescale 1ns/100ps

module tb_spill_subsystem;
   import spill_pkg::*;

   localparam int TASKS_PER_CHILD        = 4;
   localparam int LOG_CHILDREN_PER_CHUNK = 2;
   localparam int LOG_SPILL_DEPTH        = 4;
   localparam int SPILL_DEPTH            = 2**LOG_SPILL_DEPTH;
   localparam int NUM_TASKS              = 96;
   localparam int NUM_CHILDREN           = NUM_TASKS / TASKS_PER_CHILD;
   localparam int TIMEOUT_CYCLES         = 20 * NUM_TASKS + 2000;
   localparam logic [31:0] SPILL_BASE    = 32'h0000_0800;
   localparam logic [31:0] STACK_BASE    = 32'h0000_0200;
   localparam logic [31:0] PTR_ADDR      = 32'h0000_0100;

   logic        clk;
   logic        rstn;
   apb_req_t    apb;
   logic [31:0] prdata;
   logic        pready;
   logic        overflow_valid;
   logic        overflow_ready;
   task_t       overflow_task;
   logic        child_valid;
   logic        child_ready;
   child_t      child_task;
   logic        mem_req_valid;
   logic        mem_req_ready;
   mem_req_t    mem_req;
   logic        mem_rvalid;
   logic [63:0] mem_rdata;
   logic        mem_bvalid;
   logic [3:0]  mem_bid;
   logic        mem_bready;
   logic        lock_in;
   logic        lock_out;

   integer      seed = 32'h04f0_ca63;
   int          cyc = 0;
   int          errors = 0;
   int          checks = 0;
   int          tasks_in = 0;
   int          children_out = 0;
   bit          running = 0;
   bit          ov_fire = 0;
   bit          saw_full = 0;

   // reference model of the stack walk and the chunk layout
   task_t       exp_tasks [$];
   ts_t         exp_child_ts [logic [15:0]];   // expected min timestamp, keyed by child id
   int          stage = 0;                      // 0 ptr read, 1 ptr write, 2 top read, 3 chunks
   int          beat = 0;
   int          chunks_left = 0;
   int          model_ptr = 0;
   logic [15:0] next_child = '0;
   logic [3:0]  burst_id = '0;
   ts_t         burst_min = '0;

   int          lock_hold = 0;
   logic        lock_out_q = 1'b0;
   int          contentions = 0;
   bit          contention_check = 0;

   spill_subsystem #(
      .TASKS_PER_CHILD        (TASKS_PER_CHILD),
      .LOG_CHILDREN_PER_CHUNK (LOG_CHILDREN_PER_CHUNK),
      .LOG_SPILL_DEPTH        (LOG_SPILL_DEPTH),
      .LOG_IDS                (2)
   ) dut_i (.*);

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic report_failure(input string what);
      errors++;
      $display("%s", what);
   endtask

   `include "tb_mem_model.svh"

   function automatic bit is_stack_addr(input logic [31:0] addr);
      return addr == PTR_ADDR || (addr >= STACK_BASE && addr < STACK_BASE + 32'd8);
   endfunction

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      @(negedge clk);
      apb.psel   = 1'b1;
      apb.pwrite = 1'b1;
      apb.paddr  = addr;
      apb.pwdata = data;
      @(negedge clk);
      apb.penable = 1'b1;
      #1;
      check_value("pready", 64'(pready), 64'd1);
      @(negedge clk);
      apb = '0;
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
      @(negedge clk);
      apb.psel  = 1'b1;
      apb.paddr = addr;
      @(negedge clk);
      apb.penable = 1'b1;
      #1;
      check_value("pready", 64'(pready), 64'd1);
      data = prdata;
      @(negedge clk);
      apb = '0;
   endtask

   task automatic drive_overflow();
      int r;
      int hi;
      int lo;
      r  = $random(seed);
      hi = $random(seed);
      lo = $random(seed);
      if (overflow_valid && !ov_fire) return;   // hold the offer until it is taken
      overflow_valid = tasks_in < NUM_TASKS && r[2:0] != 3'd0;
      overflow_task  = task_t'({hi, lo});
   endtask

   // splitter side of the lock, with a forced clash right after a grab
   task automatic drive_lock();
      int r;
      r = $random(seed);
      if (contention_check) begin
         check_value("lock_out", 64'(lock_out), 64'd0);
         contention_check = 0;
      end
      if (lock_hold > 0) begin
         lock_hold--;
         if (lock_hold == 0) lock_in = 1'b0;
      end else if (lock_out && !lock_out_q && (contentions == 0 || r[0])) begin
         lock_in          = 1'b1;
         lock_hold        = 3 + int'(r[3:1]);
         contentions++;
         contention_check = 1;
      end else if (!lock_out && r[8:4] == 5'd0) begin
         lock_in   = 1'b1;
         lock_hold = 4 + int'(r[12:9]);
      end
      lock_out_q = lock_out;
   endtask

   task automatic observe_requests();
      task_t       expt;
      logic [31:0] exp_addr;
      if (mem_req_valid && lock_in && is_stack_addr(mem_req.addr))
         report_failure("stack request issued while the splitter holds the lock");
      if (!(mem_req_valid && mem_req_ready)) return;
      if (stage < 3) begin
         exp_addr = (stage == 2) ? STACK_BASE + 32'(model_ptr) : PTR_ADDR;
         check_value("mem_req.addr", 64'(mem_req.addr), 64'(exp_addr));
         check_value("mem_req.we", 64'(mem_req.we), 64'(stage == 1));
         check_value("mem_req.last", 64'(mem_req.last), 64'd1);
         if (stage == 1) check_value("mem_req.wdata", mem_req.wdata, 64'(model_ptr + 1));
         if (stage == 2) begin
            next_child  = stack_list[3'(model_ptr)] << LOG_CHILDREN_PER_CHUNK;
            model_ptr++;
            chunks_left = 2**LOG_CHILDREN_PER_CHUNK;
            beat        = 0;
         end
         stage++;
         return;
      end
      exp_addr = SPILL_BASE + 32'(next_child) * 32'(TASKS_PER_CHILD) + 32'(beat);
      check_value("mem_req.addr", 64'(mem_req.addr), 64'(exp_addr));
      check_value("mem_req.we", 64'(mem_req.we), 64'd1);
      check_value("mem_req.last", 64'(mem_req.last), 64'(beat == TASKS_PER_CHILD - 1));
      if (exp_tasks.size() == 0) begin
         report_failure("chunk beat written with no spilled task left to write");
         expt = task_t'(mem_req.wdata);
      end else begin
         expt = exp_tasks.pop_front();
         check_value("mem_req.wdata", mem_req.wdata, 64'(expt));
      end
      if (beat == 0) begin
         burst_id  = mem_req.id;
         burst_min = expt.ts;
      end else begin
         check_value("mem_req.id", 64'(mem_req.id), 64'(burst_id));
         if (expt.ts < burst_min) burst_min = expt.ts;
      end
      beat++;
      if (beat == TASKS_PER_CHILD) begin
         exp_child_ts[next_child] = burst_min;
         next_child++;
         beat = 0;
         chunks_left--;
         if (chunks_left == 0) stage = 0;   // group used up, next chunk needs a new stack entry
      end
   endtask

   task automatic observe_ports();
      // the queue holds exactly what sits in the spill FIFO at this point
      check_value("overflow_ready", 64'(overflow_ready),
                  64'(exp_tasks.size() < SPILL_DEPTH));
      ov_fire = overflow_valid && overflow_ready;
      if (ov_fire) begin
         exp_tasks.push_back(overflow_task);
         tasks_in++;
      end
      if (overflow_valid && !overflow_ready) saw_full = 1;
      if (child_valid && child_ready) begin
         children_out++;
         if (!exp_child_ts.exists(child_task.id)) begin
            report_failure("child task with an unknown or repeated id");
         end else begin
            check_value("child_task.ts", 64'(child_task.ts), 64'(exp_child_ts[child_task.id]));
            exp_child_ts.delete(child_task.id);
         end
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // inputs change on the falling edge, handshakes are judged once they settle
   always @(negedge clk) begin
      cyc++;
      if (running) begin
         drive_overflow();
         drive_lock();
         mem_drive();
         #1;
         observe_ports();
         observe_requests();
         mem_observe();
      end
   end

   initial begin
      while (cyc < TIMEOUT_CYCLES) @(posedge clk);
      $display("timeout after %0d cycles with %0d of %0d child tasks received",
               TIMEOUT_CYCLES, children_out, NUM_CHILDREN);
      $display("errors %0d in %0d checks", errors, checks);
      $display("SIMULATION FAILED");
      $finish;
   end

   initial begin
      logic [31:0] rd;
      rstn           = 1'b0;
      apb            = '0;
      overflow_valid = 1'b0;
      overflow_task  = '0;
      child_ready    = 1'b0;
      mem_req_ready  = 1'b0;
      mem_rvalid     = 1'b0;
      mem_rdata      = '0;
      mem_bvalid     = 1'b0;
      mem_bid        = '0;
      lock_in        = 1'b0;
      mem_init();
      repeat (16) @(negedge clk);
      rstn = 1'b1;
      apb_write(REG_SPILL_BASE, SPILL_BASE);
      apb_write(REG_STACK_BASE, STACK_BASE);
      apb_write(REG_STACK_PTR_ADDR, PTR_ADDR);
      apb_read(REG_SPILL_BASE, rd);
      check_value("REG_SPILL_BASE", 64'(rd), 64'(SPILL_BASE));
      apb_read(REG_STACK_BASE, rd);
      check_value("REG_STACK_BASE", 64'(rd), 64'(STACK_BASE));
      apb_read(REG_STACK_PTR_ADDR, rd);
      check_value("REG_STACK_PTR_ADDR", 64'(rd), 64'(PTR_ADDR));
      apb_write(REG_CTRL, 32'd1);
      apb_read(REG_CTRL, rd);
      check_value("REG_CTRL", 64'(rd), 64'd1);
      @(posedge clk);
      running = 1;
      wait (tasks_in == NUM_TASKS && children_out == NUM_CHILDREN);
      repeat (4) @(negedge clk);
      apb_read(REG_NUM_DEQ, rd);
      check_value("REG_NUM_DEQ", 64'(rd), 64'(tasks_in));
      apb_read(REG_NUM_ENQ, rd);
      check_value("REG_NUM_ENQ", 64'(rd), 64'(children_out));
      apb_read(REG_STATUS, rd);
      check_value("REG_STATUS", 64'(rd), 64'({16'd0, 16'(model_ptr - 1)}));
      apb_read(REG_CHILD_ID, rd);
      check_value("REG_CHILD_ID", 64'(rd), 64'(next_child));
      if (exp_tasks.size() != 0) report_failure("accepted overflow tasks were never written");
      if (exp_child_ts.num() != 0) report_failure("written chunks never produced a child task");
      if (contentions == 0) report_failure("lock contention never happened");
      if (!saw_full) report_failure("overflow_ready never fell while the spill FIFO was full");
      $display("errors %0d in %0d checks", errors, checks);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

/* verilog/id_free_list.sv */
`timescale 1ns/100ps

module id_free_list #(
   parameter int LOG_IDS = 2
) (
   input  logic       clk,
   input  logic       rstn,
   input  logic       alloc,
   input  logic       free_en,
   input  logic [3:0] free_id,
   output logic [3:0] next_id,
   output logic       empty
);

   localparam int NUM_IDS = 2**LOG_IDS;

   logic [3:0]         ids [NUM_IDS];
   logic [LOG_IDS-1:0] rd_ptr;
   logic [LOG_IDS-1:0] wr_ptr;
   logic [LOG_IDS:0]   count;
   logic               do_alloc;

   assign do_alloc = alloc & !empty;

   // the pool starts full, so the write pointer has already wrapped to zero
   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < NUM_IDS; i++) begin
            ids[i] <= 4'(i);
         end
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= (LOG_IDS+1)'(NUM_IDS);
      end else begin
         if (free_en) begin
            ids[wr_ptr] <= free_id;
            wr_ptr      <= wr_ptr + 1'b1;
         end
         if (do_alloc) rd_ptr <= rd_ptr + 1'b1;
         if (free_en & !do_alloc) count <= count + 1'b1;
         else if (do_alloc & !free_en) count <= count - 1'b1;
      end
   end

   assign next_id = ids[rd_ptr];
   assign empty   = (count == '0);

   // an acknowledge can only return an id that was handed out earlier
   no_free_into_full_pool: assert property (@(posedge clk) disable iff (!rstn)
      free_en |-> count != (LOG_IDS+1)'(NUM_IDS));

endmodule

/* verilog/spill_coalescer.sv */
`timescale 1ns/100ps

module spill_coalescer #(
   parameter int TASKS_PER_CHILD        = 4,
   parameter int LOG_CHILDREN_PER_CHUNK = 2,
   parameter int LOG_SPILL_DEPTH        = 4,
   parameter int LOG_IDS                = 2
) (
   input  logic                  clk,
   input  logic                  rstn,
   input  spill_pkg::coal_cfg_t  cfg,
   output spill_pkg::coal_stat_t stat,
   input  logic                  overflow_valid,
   output logic                  overflow_ready,
   input  spill_pkg::task_t      overflow_task,
   output logic                  child_valid,
   input  logic                  child_ready,
   output spill_pkg::child_t     child_task,
   output logic                  mem_req_valid,
   input  logic                  mem_req_ready,
   output spill_pkg::mem_req_t   mem_req,
   input  logic                  mem_rvalid,
   input  logic [63:0]           mem_rdata,
   input  logic                  mem_bvalid,
   input  logic [3:0]            mem_bid,
   output logic                  mem_bready,
   input  logic                  lock_in,
   output logic                  lock_out
);
   import spill_pkg::*;

   localparam int NUM_IDS = 2**LOG_IDS;
   localparam int BEAT_W  = $clog2(TASKS_PER_CHILD + 1);

   typedef enum logic [3:0] {
      COAL_INIT, COAL_GRAB_LOCK, COAL_CHECK_LOCK,
      COAL_READ_PTR, COAL_READ_PTR_WAIT,
      COAL_WRITE_PTR, COAL_WRITE_PTR_WAIT,
      COAL_READ_TOP, COAL_READ_TOP_WAIT,
      COAL_RELEASE_LOCK, COAL_IDLE,
      COAL_WRITE_TASK, COAL_WRITE_TASK_WAIT
   } coal_state_t;

   coal_state_t       state, state_next;
   logic [BEAT_W-1:0] beat, beat_next;
   logic [15:0]       stack_ptr;
   logic [15:0]       child_id;
   ts_t               coal_ts;
   ts_t               min_ts;
   logic [3:0]        reg_id;
   logic [3:0]        ptr_id;
   logic [3:0]        cur_id;
   ts_t               pending_ts [NUM_IDS];
   logic [15:0]       pending_id [NUM_IDS];

   logic   spill_full, spill_empty, spill_rd_en;
   task_t  spill_head;
   logic   child_full, child_empty, child_wr_en;
   child_t child_wr_data;
   logic   id_empty, id_alloc, id_free;
   logic   [3:0] next_id;
   logic   req_fire, first_beat, last_beat, ptr_ack;

   assign req_fire   = mem_req_valid & mem_req_ready;
   assign first_beat = (beat == '0);
   assign last_beat  = (beat == BEAT_W'(TASKS_PER_CHILD - 1));
   // the first beat of a chunk carries the id still sitting at the pool head
   assign cur_id     = (state == COAL_WRITE_TASK && !first_beat) ? reg_id : next_id;
   assign min_ts     = (first_beat || spill_head.ts < coal_ts) ? spill_head.ts : coal_ts;
   assign id_alloc   = req_fire & ((state == COAL_WRITE_PTR) |
                                   (state == COAL_WRITE_TASK & first_beat));

   // splitter wins a tie on the same cycle
   always_ff @(posedge clk) begin
      if (!rstn) begin
         lock_out <= 1'b0;
      end else if (state == COAL_GRAB_LOCK && !lock_in) begin
         lock_out <= 1'b1;
      end else if (state == COAL_CHECK_LOCK) begin
         lock_out <= !lock_in;
      end else if (state == COAL_RELEASE_LOCK) begin
         lock_out <= 1'b0;
      end
   end

   always_comb begin
      state_next    = state;
      beat_next     = beat;
      spill_rd_en   = 1'b0;
      mem_req_valid = 1'b0;
      mem_req       = '0;
      mem_req.id    = cur_id;
      case (state)
         COAL_INIT: begin
            if (cfg.start && !spill_empty && !id_empty) state_next = COAL_GRAB_LOCK;
         end
         COAL_GRAB_LOCK: begin
            if (!lock_in) state_next = COAL_CHECK_LOCK;
         end
         COAL_CHECK_LOCK: begin
            state_next = lock_in ? COAL_GRAB_LOCK : COAL_READ_PTR;
         end
         COAL_READ_PTR: begin
            mem_req_valid = 1'b1;
            mem_req.last  = 1'b1;
            mem_req.addr  = cfg.stack_ptr_addr;
            if (mem_req_ready) state_next = COAL_READ_PTR_WAIT;
         end
         COAL_READ_PTR_WAIT: begin
            if (mem_rvalid) state_next = COAL_WRITE_PTR;
         end
         COAL_WRITE_PTR: begin
            mem_req_valid = !id_empty;
            mem_req.we    = 1'b1;
            mem_req.last  = 1'b1;
            mem_req.addr  = cfg.stack_ptr_addr;
            mem_req.wdata = 64'(stack_ptr + 16'd1);
            if (!id_empty && mem_req_ready) state_next = COAL_WRITE_PTR_WAIT;
         end
         COAL_WRITE_PTR_WAIT: begin
            if (mem_bvalid && ptr_ack) state_next = COAL_READ_TOP;
         end
         COAL_READ_TOP: begin
            mem_req_valid = 1'b1;
            mem_req.last  = 1'b1;
            mem_req.addr  = cfg.stack_base + 32'(stack_ptr);
            if (mem_req_ready) state_next = COAL_READ_TOP_WAIT;
         end
         COAL_READ_TOP_WAIT: begin
            if (mem_rvalid) state_next = COAL_RELEASE_LOCK;
         end
         COAL_RELEASE_LOCK: state_next = COAL_IDLE;
         COAL_IDLE: begin
            if (!cfg.start) begin
               state_next = COAL_INIT;
            end else if (!spill_empty && !id_empty) begin
               beat_next  = '0;
               state_next = COAL_WRITE_TASK;
            end
         end
         COAL_WRITE_TASK: begin
            mem_req_valid = !spill_empty;
            mem_req.we    = 1'b1;
            mem_req.last  = last_beat;
            mem_req.addr  = cfg.spill_base + 32'(child_id) * TASKS_PER_CHILD + 32'(beat);
            mem_req.wdata = spill_head;
            if (!spill_empty && mem_req_ready) begin
               spill_rd_en = 1'b1;
               beat_next   = beat + 1'b1;
               if (last_beat) state_next = COAL_WRITE_TASK_WAIT;
            end
         end
         COAL_WRITE_TASK_WAIT: begin
            // a fresh stack entry is needed once the chunk group is used up
            state_next = (child_id[LOG_CHILDREN_PER_CHUNK-1:0] == '1) ? COAL_INIT : COAL_IDLE;
         end
         default: state_next = COAL_INIT;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state     <= COAL_INIT;
         beat      <= '0;
         stack_ptr <= '0;
         child_id  <= '0;
      end else begin
         state <= state_next;
         beat  <= beat_next;
         if (state == COAL_READ_PTR_WAIT && mem_rvalid) stack_ptr <= mem_rdata[15:0];
         if (state == COAL_READ_TOP_WAIT && mem_rvalid) begin
            child_id <= mem_rdata[15:0] << LOG_CHILDREN_PER_CHUNK;
         end else if (state == COAL_WRITE_TASK_WAIT) begin
            child_id <= child_id + 16'd1;
         end
      end
   end

   // the pending entry is written with the last beat, before any acknowledge can return
   always_ff @(posedge clk) begin
      if (id_alloc) begin
         reg_id <= next_id;
         if (state == COAL_WRITE_PTR) ptr_id <= next_id;
      end
      if (state == COAL_WRITE_TASK && req_fire) begin
         coal_ts <= min_ts;
         if (last_beat) begin
            pending_ts[cur_id[LOG_IDS-1:0]] <= min_ts;
            pending_id[cur_id[LOG_IDS-1:0]] <= child_id;
         end
      end
   end

   assign ptr_ack       = (state == COAL_WRITE_PTR_WAIT) && (mem_bid == ptr_id);
   assign mem_bready    = ptr_ack | !child_full;   // child back-pressure stalls chunk acks
   assign id_free       = mem_bvalid & mem_bready;
   assign child_wr_en   = id_free & !ptr_ack;
   assign child_wr_data = '{ts: pending_ts[mem_bid[LOG_IDS-1:0]],
                            id: pending_id[mem_bid[LOG_IDS-1:0]]};

   assign overflow_ready = !spill_full;
   assign child_valid    = !child_empty;

   sync_fifo #(
      .T         (task_t),
      .LOG_DEPTH (LOG_SPILL_DEPTH)
   ) spill_fifo (
      .clk     (clk),
      .rstn    (rstn),
      .wr_en   (overflow_valid & overflow_ready),
      .wr_data (overflow_task),
      .rd_en   (spill_rd_en),
      .rd_data (spill_head),
      .full    (spill_full),
      .empty   (spill_empty)
   );

   sync_fifo #(
      .T         (child_t),
      .LOG_DEPTH (LOG_IDS)
   ) child_fifo (
      .clk     (clk),
      .rstn    (rstn),
      .wr_en   (child_wr_en),
      .wr_data (child_wr_data),
      .rd_en   (child_valid & child_ready),
      .rd_data (child_task),
      .full    (child_full),
      .empty   (child_empty)
   );

   id_free_list #(
      .LOG_IDS (LOG_IDS)
   ) write_ids (
      .clk     (clk),
      .rstn    (rstn),
      .alloc   (id_alloc),
      .free_en (id_free),
      .free_id (mem_bid),
      .next_id (next_id),
      .empty   (id_empty)
   );

   assign stat.state     = state;
   assign stat.stack_ptr = stack_ptr;
   assign stat.child_id  = child_id;
   assign stat.enq_fire  = child_valid & child_ready;
   assign stat.deq_fire  = overflow_valid & overflow_ready;

   mem_req_held: assert property (@(posedge clk) disable iff (!rstn)
      mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req));

   // the lock register lags the fsm by a cycle, so this ties the two together
   stack_req_locked: assert property (@(posedge clk) disable iff (!rstn)
      mem_req_valid && (state inside {COAL_READ_PTR, COAL_WRITE_PTR, COAL_READ_TOP})
      |-> lock_out);

endmodule

/* verilog/spill_pkg.sv */
package spill_pkg;

   typedef logic [31:0] ts_t;

   // one task fills exactly one 64-bit memory word
   typedef struct packed {
      ts_t         ts;
      logic [15:0] locale;
      logic [3:0]  ttype;
      logic [11:0] args;
   } task_t;

   typedef struct packed {
      ts_t         ts;   // smallest timestamp in the chunk
      logic [15:0] id;
   } child_t;

   typedef struct packed {
      logic        we;
      logic        last;
      logic [3:0]  id;
      logic [31:0] addr;   // word address
      logic [63:0] wdata;
   } mem_req_t;

   typedef struct packed {
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [7:0]  paddr;
      logic [31:0] pwdata;
   } apb_req_t;

   localparam logic [7:0] REG_CTRL           = 8'h00;   // bit 0 is start
   localparam logic [7:0] REG_SPILL_BASE     = 8'h04;
   localparam logic [7:0] REG_STACK_BASE     = 8'h08;
   localparam logic [7:0] REG_STACK_PTR_ADDR = 8'h0C;
   localparam logic [7:0] REG_NUM_ENQ        = 8'h10;   // child tasks out
   localparam logic [7:0] REG_NUM_DEQ        = 8'h14;   // overflow tasks in
   localparam logic [7:0] REG_STATUS         = 8'h18;
   localparam logic [7:0] REG_CHILD_ID       = 8'h1C;

   typedef struct packed {
      logic        start;
      logic [31:0] spill_base;
      logic [31:0] stack_base;
      logic [31:0] stack_ptr_addr;
   } coal_cfg_t;

   typedef struct packed {
      logic [3:0]  state;
      logic [15:0] stack_ptr;
      logic [15:0] child_id;
      logic        enq_fire;
      logic        deq_fire;
   } coal_stat_t;

endpackage

/* verilog/spill_regs.sv */
`timescale 1ns/100ps

module spill_regs (
   input  logic                  clk,
   input  logic                  rstn,
   input  spill_pkg::apb_req_t   apb,
   output logic [31:0]           prdata,
   output logic                  pready,
   input  spill_pkg::coal_stat_t stat,
   output spill_pkg::coal_cfg_t  cfg
);
   import spill_pkg::*;

   logic        wr_access;
   logic        rd_access;
   logic [31:0] num_enq;
   logic [31:0] num_deq;

   assign wr_access = apb.psel & apb.penable & apb.pwrite;
   assign rd_access = apb.psel & apb.penable & !apb.pwrite;
   assign pready    = 1'b1;   // every access completes with no wait state

   always_ff @(posedge clk) begin
      if (!rstn) begin
         cfg <= '0;
      end else if (wr_access) begin
         case (apb.paddr)
            REG_CTRL:           cfg.start          <= apb.pwdata[0];
            REG_SPILL_BASE:     cfg.spill_base     <= apb.pwdata;
            REG_STACK_BASE:     cfg.stack_base     <= apb.pwdata;
            REG_STACK_PTR_ADDR: cfg.stack_ptr_addr <= apb.pwdata;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         num_enq <= '0;
         num_deq <= '0;
      end else begin
         if (stat.enq_fire) num_enq <= num_enq + 32'd1;
         if (stat.deq_fire) num_deq <= num_deq + 32'd1;
      end
   end

   always_comb begin
      prdata = '0;
      if (rd_access) begin
         case (apb.paddr)
            REG_CTRL:           prdata = {31'd0, cfg.start};
            REG_SPILL_BASE:     prdata = cfg.spill_base;
            REG_STACK_BASE:     prdata = cfg.stack_base;
            REG_STACK_PTR_ADDR: prdata = cfg.stack_ptr_addr;
            REG_NUM_ENQ:        prdata = num_enq;
            REG_NUM_DEQ:        prdata = num_deq;
            REG_STATUS:         prdata = {12'd0, stat.state, stat.stack_ptr};
            REG_CHILD_ID:       prdata = {16'd0, stat.child_id};
            default:            prdata = '0;
         endcase
      end
   end

endmodule

/* verilog/spill_subsystem.sv */
`timescale 1ns/100ps

module spill_subsystem #(
   parameter int TASKS_PER_CHILD        = 4,
   parameter int LOG_CHILDREN_PER_CHUNK = 2,
   parameter int LOG_SPILL_DEPTH        = 4,
   parameter int LOG_IDS                = 2   // at most 4, the id field is 4 bits
) (
   input  logic                clk,
   input  logic                rstn,
   input  spill_pkg::apb_req_t apb,
   output logic [31:0]         prdata,
   output logic                pready,
   input  logic                overflow_valid,
   output logic                overflow_ready,
   input  spill_pkg::task_t    overflow_task,
   output logic                child_valid,
   input  logic                child_ready,
   output spill_pkg::child_t   child_task,
   output logic                mem_req_valid,
   input  logic                mem_req_ready,
   output spill_pkg::mem_req_t mem_req,
   input  logic                mem_rvalid,
   input  logic [63:0]         mem_rdata,
   input  logic                mem_bvalid,
   input  logic [3:0]          mem_bid,
   output logic                mem_bready,
   input  logic                lock_in,
   output logic                lock_out
);
   import spill_pkg::*;

   coal_cfg_t  cfg;
   coal_stat_t stat;

   spill_regs regs (
      .clk    (clk),
      .rstn   (rstn),
      .apb    (apb),
      .prdata (prdata),
      .pready (pready),
      .stat   (stat),
      .cfg    (cfg)
   );

   spill_coalescer #(
      .TASKS_PER_CHILD        (TASKS_PER_CHILD),
      .LOG_CHILDREN_PER_CHUNK (LOG_CHILDREN_PER_CHUNK),
      .LOG_SPILL_DEPTH        (LOG_SPILL_DEPTH),
      .LOG_IDS                (LOG_IDS)
   ) coalescer (
      .clk            (clk),
      .rstn           (rstn),
      .cfg            (cfg),
      .stat           (stat),
      .overflow_valid (overflow_valid),
      .overflow_ready (overflow_ready),
      .overflow_task  (overflow_task),
      .child_valid    (child_valid),
      .child_ready    (child_ready),
      .child_task     (child_task),
      .mem_req_valid  (mem_req_valid),
      .mem_req_ready  (mem_req_ready),
      .mem_req        (mem_req),
      .mem_rvalid     (mem_rvalid),
      .mem_rdata      (mem_rdata),
      .mem_bvalid     (mem_bvalid),
      .mem_bid        (mem_bid),
      .mem_bready     (mem_bready),
      .lock_in        (lock_in),
      .lock_out       (lock_out)
   );

endmodule

/* verilog/sync_fifo.sv */
`timescale 1ns/100ps

module sync_fifo #(
   parameter type T         = logic [31:0],
   parameter int  LOG_DEPTH = 4
) (
   input  logic clk,
   input  logic rstn,
   input  logic wr_en,
   input  T     wr_data,
   input  logic rd_en,
   output T     rd_data,
   output logic full,
   output logic empty
);

   localparam int DEPTH = 2**LOG_DEPTH;

   T                     mem [DEPTH];
   logic [LOG_DEPTH-1:0] wr_ptr;
   logic [LOG_DEPTH-1:0] rd_ptr;
   logic [LOG_DEPTH:0]   count;
   logic                 do_wr;
   logic                 do_rd;

   assign do_wr = wr_en & !full;
   assign do_rd = rd_en & !empty;

   // pointers wrap on their own since the depth is a power of two
   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) wr_ptr <= wr_ptr + 1'b1;
         if (do_rd) rd_ptr <= rd_ptr + 1'b1;
         if (do_wr & !do_rd) count <= count + 1'b1;
         else if (do_rd & !do_wr) count <= count - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (do_wr) mem[wr_ptr] <= wr_data;
   end

   assign rd_data = mem[rd_ptr];   // head is shown ahead of the read
   assign full    = (count == (LOG_DEPTH+1)'(DEPTH));
   assign empty   = (count == '0);

   // the writer and reader live in other modules and must watch the flags
   no_write_when_full: assert property (@(posedge clk) disable iff (!rstn)
      wr_en |-> !full);

   no_read_when_empty: assert property (@(posedge clk) disable iff (!rstn)
      rd_en |-> !empty);

endmodule
